//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // IR_NOP is also the pipeline bubble
    typedef enum logic [3:0] {
        IR_NOP,
        IR_OP,
        IR_OPIMM,
        IR_LUI,
        IR_AUIPC,
        IR_JAL,
        IR_JALR,
        IR_BRANCH
    } ir_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_e;

    // Opcode classes that the core does not run become bubbles
    function automatic ir_type_e ir_type_of(input logic [XLEN-1:0] ir);
        ir_type_e t;
        case (ir[6:0])
            7'b0110011: t = IR_OP;
            7'b0010011: t = IR_OPIMM;
            7'b0110111: t = IR_LUI;
            7'b0010111: t = IR_AUIPC;
            7'b1101111: t = IR_JAL;
            7'b1100111: t = (ir[14:12] == 3'b000) ? IR_JALR : IR_NOP;
            // funct3 010 and 011 are reserved for branches
            7'b1100011: t = (ir[14:13] == 2'b01) ? IR_NOP : IR_BRANCH;
            default:    t = IR_NOP;
        endcase
        return t;
    endfunction

endpackage

`default_nettype wire

//--- design/fetch_unit.sv
`default_nettype none

module fetch_unit
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_freeze,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  logic            i_pred_taken,
    input  logic [XLEN-1:0] i_pred_target,
    input  logic [XLEN-1:0] i_idt,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_id_ir,
    output logic [XLEN-1:0] o_id_pc,
    output logic            o_id_pred_taken,
    output logic [XLEN-1:0] o_id_pred_target
);

    // All-zero word decodes as IR_NOP
    localparam logic [XLEN-1:0] NOP_WORD = '0;

    logic            if_ctrl;
    logic            if_pred_taken;
    logic [XLEN-1:0] pc_next;

    // Table hits only count for words that can transfer control
    assign if_ctrl       = ir_type_of(i_idt) inside {IR_JAL, IR_JALR, IR_BRANCH};
    assign if_pred_taken = i_pred_taken && if_ctrl;

    always_comb begin
        if (i_flush) begin
            pc_next = i_redirect_pc;
        end else if (if_pred_taken) begin
            pc_next = i_pred_target;
        end else begin
            pc_next = o_pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= RESET_PC;
        end else if (!i_freeze) begin
            o_pc <= pc_next;
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ir         <= NOP_WORD;
            o_id_pred_taken <= 1'b0;
        end else if (!i_freeze) begin
            o_id_ir         <= i_flush ? NOP_WORD : i_idt;
            o_id_pred_taken <= if_pred_taken && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_id_pc          <= o_pc;
            o_id_pred_target <= i_pred_target;
        end
    end

    // JALR targets and table entries must keep the PC on a word boundary
    pc_aligned_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_pc[1:0] == 2'b00)
        else $error("fetch PC %h not word aligned", o_pc);

endmodule

`default_nettype wire

//--- design/decoder.sv
`default_nettype none

module decoder
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_freeze,
    input  logic                  i_flush,
    input  logic [XLEN-1:0]       i_ir,
    input  logic [XLEN-1:0]       i_pc,
    input  logic                  i_pred_taken,
    input  logic [XLEN-1:0]       i_pred_target,
    input  logic [XLEN-1:0]       i_rf_a,
    input  logic [XLEN-1:0]       i_rf_b,
    input  logic [XLEN-1:0]       i_ex_result,
    input  logic [XLEN-1:0]       i_wb_data,
    input  fwd_sel_e              i_fwd_a,
    input  fwd_sel_e              i_fwd_b,
    output logic [REG_ADDR_W-1:0] o_rs1,
    output logic [REG_ADDR_W-1:0] o_rs2,
    output ir_type_e              o_ex_type,
    output alu_op_e               o_ex_alu_op,
    output logic [XLEN-1:0]       o_ex_a,
    output logic [XLEN-1:0]       o_ex_b,
    output logic [XLEN-1:0]       o_ex_imm,
    output logic [XLEN-1:0]       o_ex_pc,
    output logic [REG_ADDR_W-1:0] o_ex_rd,
    output logic [2:0]            o_ex_funct3,
    output logic                  o_ex_pred_taken,
    output logic [XLEN-1:0]       o_ex_pred_target
);

    ir_type_e              id_type;
    alu_op_e               id_alu_op;
    logic                  id_alt;
    logic [XLEN-1:0]       id_imm;
    logic [REG_ADDR_W-1:0] id_rd;

    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel, input logic [XLEN-1:0] rf,
                                             input logic [XLEN-1:0] ex,
                                             input logic [XLEN-1:0] wb);
        case (sel)
            FWD_EX:  return ex;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign id_type = ir_type_of(i_ir);
    assign o_rs1   = i_ir[19:15];
    assign o_rs2   = i_ir[24:20];
    assign id_rd   = (id_type == IR_NOP || id_type == IR_BRANCH) ? '0 : i_ir[11:7];

    // Bit 30 picks SUB only for register ops, SRA for both
    assign id_alt = i_ir[30] && (id_type == IR_OP || i_ir[14:12] == 3'b101);

    always_comb begin
        id_alu_op = ALU_ADD;
        if (id_type == IR_OP || id_type == IR_OPIMM) begin
            case (i_ir[14:12])
                3'b000:  id_alu_op = id_alt ? ALU_SUB : ALU_ADD;
                3'b001:  id_alu_op = ALU_SLL;
                3'b010:  id_alu_op = ALU_SLT;
                3'b011:  id_alu_op = ALU_SLTU;
                3'b100:  id_alu_op = ALU_XOR;
                3'b101:  id_alu_op = id_alt ? ALU_SRA : ALU_SRL;
                3'b110:  id_alu_op = ALU_OR;
                default: id_alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (id_type)
            IR_LUI, IR_AUIPC: id_imm = {i_ir[31:12], 12'b0};
            IR_JAL:    id_imm = {{12{i_ir[31]}}, i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0};
            IR_BRANCH: id_imm = {{20{i_ir[31]}}, i_ir[7], i_ir[30:25], i_ir[11:8], 1'b0};
            default:   id_imm = {{20{i_ir[31]}}, i_ir[31:20]};
        endcase
    end

    // ID/EX
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_type       <= IR_NOP;
            o_ex_rd         <= '0;
            o_ex_pred_taken <= 1'b0;
        end else if (!i_freeze) begin
            o_ex_type       <= i_flush ? IR_NOP : id_type;
            o_ex_rd         <= i_flush ? '0 : id_rd;
            o_ex_pred_taken <= i_pred_taken && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_ex_alu_op      <= id_alu_op;
            o_ex_a           <= pick(i_fwd_a, i_rf_a, i_ex_result, i_wb_data);
            o_ex_b           <= pick(i_fwd_b, i_rf_b, i_ex_result, i_wb_data);
            o_ex_imm         <= id_imm;
            o_ex_pc          <= i_pc;
            o_ex_funct3      <= i_ir[14:12];
            o_ex_pred_target <= i_pred_target;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata,
    input  logic [REG_ADDR_W-1:0] i_raddr_a,
    input  logic [REG_ADDR_W-1:0] i_raddr_b,
    output logic [XLEN-1:0]       o_rdata_a,
    output logic [XLEN-1:0]       o_rdata_b
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Same-cycle write is visible to the reader
    function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] stored);
        if (addr == '0) begin
            return '0;
        end else if (i_we && i_waddr == addr) begin
            return i_wdata;
        end
        return stored;
    endfunction

    always_comb begin
        o_rdata_a = rd_port(i_raddr_a, regs[i_raddr_a]);
        o_rdata_b = rd_port(i_raddr_b, regs[i_raddr_b]);
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`default_nettype none

module execute_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_freeze,
    input  ir_type_e              i_type,
    input  alu_op_e               i_alu_op,
    input  logic [XLEN-1:0]       i_a,
    input  logic [XLEN-1:0]       i_b,
    input  logic [XLEN-1:0]       i_imm,
    input  logic [XLEN-1:0]       i_pc,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [2:0]            i_funct3,
    input  logic                  i_pred_taken,
    input  logic [XLEN-1:0]       i_pred_target,
    output logic [XLEN-1:0]       o_result,
    output logic                  o_redirect,
    output logic [XLEN-1:0]       o_target,
    output logic                  o_upd_en,
    output logic [XLEN-1:0]       o_upd_pc,
    output logic                  o_upd_taken,
    output logic [XLEN-1:0]       o_upd_target,
    output logic                  o_wb_en,
    output logic [REG_ADDR_W-1:0] o_wb_addr,
    output logic [XLEN-1:0]       o_wb_data
);

    logic            is_ctrl;
    logic            cond;
    logic            taken;
    logic            wb_valid;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] pred_next;

    assign op_b     = (i_type == IR_OP) ? i_b : i_imm;
    assign pc_plus4 = i_pc + XLEN'(4);

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  alu_out = i_a - op_b;
            ALU_SLL:  alu_out = i_a << op_b[4:0];
            ALU_SLT:  alu_out = XLEN'($signed(i_a) < $signed(op_b));
            ALU_SLTU: alu_out = XLEN'(i_a < op_b);
            ALU_XOR:  alu_out = i_a ^ op_b;
            ALU_SRL:  alu_out = i_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(i_a) >>> op_b[4:0];
            ALU_OR:   alu_out = i_a | op_b;
            ALU_AND:  alu_out = i_a & op_b;
            default:  alu_out = i_a + op_b;
        endcase
    end

    always_comb begin
        case (i_type)
            IR_LUI:          o_result = i_imm;
            IR_AUIPC:        o_result = i_pc + i_imm;
            IR_JAL, IR_JALR: o_result = pc_plus4;
            default:         o_result = alu_out;
        endcase
    end

    always_comb begin
        case (i_funct3)
            3'b000:  cond = i_a == i_b;
            3'b001:  cond = i_a != i_b;
            3'b100:  cond = $signed(i_a) < $signed(i_b);
            3'b101:  cond = $signed(i_a) >= $signed(i_b);
            3'b110:  cond = i_a < i_b;
            default: cond = i_a >= i_b;
        endcase
    end

    assign is_ctrl     = i_type inside {IR_JAL, IR_JALR, IR_BRANCH};
    assign taken       = i_type == IR_JAL || i_type == IR_JALR || (i_type == IR_BRANCH && cond);
    assign jump_target = (i_type == IR_JALR) ? (i_a + i_imm) & ~XLEN'(1) : i_pc + i_imm;

    // Mispredicted when the fetched successor differs from the real one
    assign o_target   = taken ? jump_target : pc_plus4;
    assign pred_next  = i_pred_taken ? i_pred_target : pc_plus4;
    assign o_redirect = is_ctrl && (o_target != pred_next);

    assign o_upd_en     = is_ctrl && !i_freeze;
    assign o_upd_pc     = i_pc;
    assign o_upd_taken  = taken;
    assign o_upd_target = jump_target;

    // EX/WB
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_valid <= 1'b0;
        end else if (!i_freeze) begin
            wb_valid <= i_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_wb_addr <= i_rd;
            o_wb_data <= o_result;
        end
    end

    // Held write-back is reported once when the freeze lifts
    assign o_wb_en = wb_valid && !i_freeze;

    // Flush leaves a bubble in EX that cannot redirect again
    redirect_bubble_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_redirect && !i_freeze |=> i_type == IR_NOP && !o_redirect)
        else $error("EX not a bubble after redirect");

endmodule

`default_nettype wire

//--- design/jump_predictor.sv
`default_nettype none

module jump_predictor
    import core_pkg::*;
#(
    parameter int PRED_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic [XLEN-1:0] i_pc,
    input  logic            i_upd_en,
    input  logic [XLEN-1:0] i_upd_pc,
    input  logic            i_upd_taken,
    input  logic [XLEN-1:0] i_upd_target,
    output logic            o_pred_taken,
    output logic [XLEN-1:0] o_pred_target
);

    localparam int IDX_W = $clog2(PRED_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;

    logic [PRED_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]        tags    [PRED_ENTRIES];
    logic [XLEN-1:0]         targets [PRED_ENTRIES];
    logic [IDX_W-1:0]        rd_idx;
    logic [IDX_W-1:0]        wr_idx;

    // Word index from the low PC bits
    assign rd_idx = i_pc[IDX_W+1:2];
    assign wr_idx = i_upd_pc[IDX_W+1:2];

    assign o_pred_taken  = valid[rd_idx] && tags[rd_idx] == i_pc[XLEN-1:IDX_W+2];
    assign o_pred_target = targets[rd_idx];

    // Not-taken outcome drops the entry
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid <= '0;
        end else if (i_upd_en) begin
            valid[wr_idx] <= i_upd_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (i_upd_en && i_upd_taken) begin
            tags[wr_idx]    <= i_upd_pc[XLEN-1:IDX_W+2];
            targets[wr_idx] <= i_upd_target;
        end
    end

endmodule

`default_nettype wire

//--- design/pipeline_ctrl.sv
`default_nettype none

module pipeline_ctrl
    import core_pkg::*;
(
    input  logic                  i_acki_n,
    input  logic                  i_ex_redirect,
    input  logic [REG_ADDR_W-1:0] i_id_rs1,
    input  logic [REG_ADDR_W-1:0] i_id_rs2,
    input  logic [REG_ADDR_W-1:0] i_ex_rd,
    input  logic                  i_ex_writes,
    input  logic [REG_ADDR_W-1:0] i_wb_rd,
    input  logic                  i_wb_en,
    output logic                  o_freeze,
    output logic                  o_flush,
    output fwd_sel_e              o_fwd_a,
    output fwd_sel_e              o_fwd_b
);

    // Younger producer wins and x0 is never forwarded
    function automatic fwd_sel_e fwd_of(input logic [REG_ADDR_W-1:0] rs,
                                        input logic [REG_ADDR_W-1:0] ex_rd,
                                        input logic                  ex_writes,
                                        input logic [REG_ADDR_W-1:0] wb_rd,
                                        input logic                  wb_en);
        if (rs == '0) begin
            return FWD_RF;
        end else if (ex_writes && rs == ex_rd) begin
            return FWD_EX;
        end else if (wb_en && rs == wb_rd) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    // Instruction memory not ready stalls every stage
    assign o_freeze = i_acki_n;
    assign o_flush  = i_ex_redirect && !o_freeze;

    always_comb begin
        o_fwd_a = fwd_of(i_id_rs1, i_ex_rd, i_ex_writes, i_wb_rd, i_wb_en);
        o_fwd_b = fwd_of(i_id_rs2, i_ex_rd, i_ex_writes, i_wb_rd, i_wb_en);
    end

endmodule

`default_nettype wire

//--- design/core_top.sv
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC     = '0,
    parameter int              PRED_ENTRIES = 16
) (
    input  logic                  clk,
    input  logic                  i_arst_n,

    // Instruction memory
    output logic [XLEN-1:0]       o_iad,
    input  logic [XLEN-1:0]       i_idt,
    input  logic                  i_acki_n,

    // Retire port
    output logic                  o_wb_en,
    output logic [REG_ADDR_W-1:0] o_wb_addr,
    output logic [XLEN-1:0]       o_wb_data
);

    // IF
    logic [XLEN-1:0]       if_pc;
    logic                  pred_taken;
    logic [XLEN-1:0]       pred_target;

    // IF/ID
    logic [XLEN-1:0]       id_ir;
    logic [XLEN-1:0]       id_pc;
    logic                  id_pred_taken;
    logic [XLEN-1:0]       id_pred_target;

    // ID
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [XLEN-1:0]       rf_a;
    logic [XLEN-1:0]       rf_b;

    // ID/EX
    ir_type_e              ex_type;
    alu_op_e               ex_alu_op;
    logic [XLEN-1:0]       ex_a;
    logic [XLEN-1:0]       ex_b;
    logic [XLEN-1:0]       ex_imm;
    logic [XLEN-1:0]       ex_pc;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [2:0]            ex_funct3;
    logic                  ex_pred_taken;
    logic [XLEN-1:0]       ex_pred_target;

    // EX
    logic [XLEN-1:0]       ex_result;
    logic                  ex_redirect;
    logic [XLEN-1:0]       ex_target;
    logic                  upd_en;
    logic [XLEN-1:0]       upd_pc;
    logic                  upd_taken;
    logic [XLEN-1:0]       upd_target;

    // Control
    logic                  freeze;
    logic                  flush;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;

    assign o_iad = if_pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_freeze(freeze),
        .i_flush(flush),
        .i_redirect_pc(ex_target),
        .i_pred_taken(pred_taken),
        .i_pred_target(pred_target),
        .i_idt(i_idt),
        .o_pc(if_pc),
        .o_id_ir(id_ir),
        .o_id_pc(id_pc),
        .o_id_pred_taken(id_pred_taken),
        .o_id_pred_target(id_pred_target)
    );

    jump_predictor #(
        .PRED_ENTRIES(PRED_ENTRIES)
    ) jump_predictor_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_pc(if_pc),
        .i_upd_en(upd_en),
        .i_upd_pc(upd_pc),
        .i_upd_taken(upd_taken),
        .i_upd_target(upd_target),
        .o_pred_taken(pred_taken),
        .o_pred_target(pred_target)
    );

    decoder decoder_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_freeze(freeze),
        .i_flush(flush),
        .i_ir(id_ir),
        .i_pc(id_pc),
        .i_pred_taken(id_pred_taken),
        .i_pred_target(id_pred_target),
        .i_rf_a(rf_a),
        .i_rf_b(rf_b),
        .i_ex_result(ex_result),
        .i_wb_data(o_wb_data),
        .i_fwd_a(fwd_a),
        .i_fwd_b(fwd_b),
        .o_rs1(id_rs1),
        .o_rs2(id_rs2),
        .o_ex_type(ex_type),
        .o_ex_alu_op(ex_alu_op),
        .o_ex_a(ex_a),
        .o_ex_b(ex_b),
        .o_ex_imm(ex_imm),
        .o_ex_pc(ex_pc),
        .o_ex_rd(ex_rd),
        .o_ex_funct3(ex_funct3),
        .o_ex_pred_taken(ex_pred_taken),
        .o_ex_pred_target(ex_pred_target)
    );

    reg_file reg_file_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_we(o_wb_en),
        .i_waddr(o_wb_addr),
        .i_wdata(o_wb_data),
        .i_raddr_a(id_rs1),
        .i_raddr_b(id_rs2),
        .o_rdata_a(rf_a),
        .o_rdata_b(rf_b)
    );

    execute_unit execute_unit_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_freeze(freeze),
        .i_type(ex_type),
        .i_alu_op(ex_alu_op),
        .i_a(ex_a),
        .i_b(ex_b),
        .i_imm(ex_imm),
        .i_pc(ex_pc),
        .i_rd(ex_rd),
        .i_funct3(ex_funct3),
        .i_pred_taken(ex_pred_taken),
        .i_pred_target(ex_pred_target),
        .o_result(ex_result),
        .o_redirect(ex_redirect),
        .o_target(ex_target),
        .o_upd_en(upd_en),
        .o_upd_pc(upd_pc),
        .o_upd_taken(upd_taken),
        .o_upd_target(upd_target),
        .o_wb_en(o_wb_en),
        .o_wb_addr(o_wb_addr),
        .o_wb_data(o_wb_data)
    );

    pipeline_ctrl pipeline_ctrl_i (
        .i_acki_n(i_acki_n),
        .i_ex_redirect(ex_redirect),
        .i_id_rs1(id_rs1),
        .i_id_rs2(id_rs2),
        .i_ex_rd(ex_rd),
        .i_ex_writes(ex_type != IR_NOP),
        .i_wb_rd(o_wb_addr),
        .i_wb_en(o_wb_en),
        .o_freeze(freeze),
        .o_flush(flush),
        .o_fwd_a(fwd_a),
        .o_fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

//--- tb/core_tb.sv
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0100;
    localparam int              PROG_WORDS   = 36;
    localparam int              MAX_CYCLES   = 2000;
    localparam int              DRAIN_CYCLES = 40;
    localparam int              OP_IMM       = 'h13;
    localparam int              OP_LUI       = 'h37;
    localparam int              OP_AUIPC     = 'h17;
    localparam int              OP_JALR      = 'h67;

    logic                  clk;
    logic                  i_arst_n;
    logic                  i_acki_n;
    logic [XLEN-1:0]       i_idt;
    logic [XLEN-1:0]       o_iad;
    logic                  o_wb_en;
    logic [REG_ADDR_W-1:0] o_wb_addr;
    logic [XLEN-1:0]       o_wb_data;

    logic [XLEN-1:0]       prog [PROG_WORDS];
    logic [REG_ADDR_W-1:0] exp_addr [$];
    logic [XLEN-1:0]       exp_data [$];
    logic                  stall_en;
    integer                seed = 32'ha4af;
    int                    val_errs;
    int                    misc_errs;

    core_top #(
        .RESET_PC(RESET_PC),
        .PRED_ENTRIES(16)
    ) dut_i (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .o_iad(o_iad),
        .i_idt(i_idt),
        .i_acki_n(i_acki_n),
        .o_wb_en(o_wb_en),
        .o_wb_addr(o_wb_addr),
        .o_wb_data(o_wb_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_u(input int imm20, input int rd, input int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
                                          input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // Words outside the program come from an address hash
    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr >= RESET_PC && idx < PROG_WORDS) begin
            return prog[idx];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3a5;
    endfunction

    // Instruction memory answers in the same cycle
    always @(posedge clk) begin
        #2;
        i_acki_n = stall_en ? (($random(seed) & 3) == 0) : 1'b0;
        i_idt    = fetch_word(o_iad);
    end

    task automatic build_program();
        prog[0]  = enc_i(5, 0, 0, 1, OP_IMM);
        prog[1]  = enc_i(3, 1, 0, 2, OP_IMM);
        prog[2]  = enc_r(0, 2, 1, 0, 3);
        prog[3]  = enc_r('h20, 1, 3, 0, 4);
        prog[4]  = enc_u('h12345, 5, OP_LUI);
        prog[5]  = enc_i('h678, 5, 0, 5, OP_IMM);
        prog[6]  = enc_i(-1, 5, 4, 6, OP_IMM);
        // srai x7, x6, 4
        prog[7]  = enc_i('h404, 6, 5, 7, OP_IMM);
        prog[8]  = enc_r(0, 1, 7, 2, 8);
        prog[9]  = enc_r(0, 1, 7, 3, 9);
        prog[10] = enc_i(7, 0, 0, 0, OP_IMM);
        prog[11] = enc_r(0, 1, 0, 0, 10);
        prog[12] = enc_u(1, 11, OP_AUIPC);
        // Loop of four passes
        prog[13] = enc_i(4, 0, 0, 12, OP_IMM);
        prog[14] = enc_i(0, 0, 0, 13, OP_IMM);
        prog[15] = enc_r(0, 12, 13, 0, 13);
        prog[16] = enc_i(-1, 12, 0, 12, OP_IMM);
        prog[17] = enc_b(-8, 0, 12, 1);
        prog[18] = enc_b(8, 1, 12, 0);
        prog[19] = enc_b(8, 2, 1, 4);
        prog[20] = enc_i(99, 0, 0, 14, OP_IMM);
        prog[21] = enc_j(12, 15);
        prog[22] = enc_i(98, 0, 0, 14, OP_IMM);
        prog[23] = enc_i(97, 0, 0, 14, OP_IMM);
        prog[24] = enc_u(0, 16, OP_AUIPC);
        prog[25] = enc_i(16, 16, 0, 17, OP_JALR);
        prog[26] = enc_i(96, 0, 0, 14, OP_IMM);
        prog[27] = enc_i(95, 0, 0, 14, OP_IMM);
        prog[28] = enc_r(0, 1, 5, 5, 18);
        prog[29] = enc_r(0, 3, 18, 6, 19);
        prog[30] = enc_r(0, 5, 19, 7, 20);
        prog[31] = enc_r(0, 1, 1, 1, 21);
        prog[32] = enc_b(8, 2, 1, 7);
        prog[33] = enc_b(8, 1, 2, 5);
        prog[34] = enc_i(94, 0, 0, 14, OP_IMM);
        // Self loop ends the program
        prog[35] = enc_j(0, 0);
    endtask

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ISA-level model that lists the expected register writes in order
    task automatic run_reference();
        logic [XLEN-1:0] regs [32];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ir;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] res;
        logic [2:0]      f3;
        logic            wr;
        int              idx;
        int              steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = RESET_PC;
        for (steps = 0; steps < 1000; steps++) begin
            idx = (pc - RESET_PC) >> 2;
            if (pc < RESET_PC || idx >= PROG_WORDS) begin
                $display("Reference model ran outside the program at %h", pc);
                misc_errs++;
                break;
            end
            ir      = prog[idx];
            f3      = ir[14:12];
            a       = regs[ir[19:15]];
            b       = regs[ir[24:20]];
            imm_i   = {{20{ir[31]}}, ir[31:20]};
            imm_b   = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            imm_j   = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (ir[6:0])
                7'h33: res = alu_ref(f3, ir[30], a, b);
                7'h13: res = alu_ref(f3, f3 == 3'd5 && ir[30], a, imm_i);
                7'h37: res = {ir[31:12], 12'b0};
                7'h17: res = pc + {ir[31:12], 12'b0};
                7'h6f: begin
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                7'h67: begin
                    res     = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b)) begin
                        next_pc = pc + imm_b;
                    end
                end
            endcase
            if (wr && ir[11:7] != 5'd0) begin
                regs[ir[11:7]] = res;
                exp_addr.push_back(ir[11:7]);
                exp_data.push_back(res);
            end
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
    endtask

    task automatic check_reg(input logic [REG_ADDR_W-1:0] exp_rd,
                             input logic [XLEN-1:0] exp_val);
        if (o_wb_addr !== exp_rd) begin
            $display("ERR %0t o_wb_addr expected %0d got %0d", $time, exp_rd, o_wb_addr);
            val_errs++;
        end
        if (o_wb_data !== exp_val) begin
            $display("ERR %0t o_wb_data expected %h got %h", $time, exp_val, o_wb_data);
            val_errs++;
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] exp_pc);
        if (o_iad !== exp_pc) begin
            $display("ERR %0t o_iad expected %h got %h", $time, exp_pc, o_iad);
            val_errs++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        i_arst_n = 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (o_wb_en) begin
                $display("Write-back reported while reset is active at %0t", $time);
                misc_errs++;
            end
        end
        @(posedge clk);
        #2;
        i_arst_n = 1'b1;
        @(negedge clk);
        check_pc(RESET_PC);
        if (o_wb_en) begin
            $display("Write-back reported right after reset at %0t", $time);
            misc_errs++;
        end
    endtask

    // Retires are sampled at the falling edge, where they are stable
    task automatic run_program(input logic stall);
        int got;
        int cycles;
        stall_en = stall;
        apply_reset();
        got    = 0;
        cycles = 0;
        while (got < exp_addr.size() && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (o_wb_en) begin
                check_reg(exp_addr[got], exp_data[got]);
                got++;
            end
        end
        if (got < exp_addr.size()) begin
            $display("Timed out with %0d of %0d write-backs seen (stalls %0d)",
                     got, exp_addr.size(), stall);
            misc_errs++;
        end
        // Core now spins in the final self loop
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (o_wb_en) begin
                $display("Extra write-back to x%0d at %0t after the program ended",
                         o_wb_addr, $time);
                misc_errs++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        i_arst_n  = 1'b0;
        i_acki_n  = 1'b0;
        i_idt     = '0;
        stall_en  = 1'b0;
        val_errs  = 0;
        misc_errs = 0;
        build_program();
        run_reference();
        run_program(1'b0);
        run_program(1'b1);
        $display("Errors: %0d value, %0d other", val_errs, misc_errs);
        if (val_errs == 0 && misc_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/core_pkg.sv
design/fetch_unit.sv
design/decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/jump_predictor.sv
design/pipeline_ctrl.sv
design/core_top.sv
tb/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module core_tb -f src.f
./obj_dir/Vcore_tb | tee sim.log

# A missing pass line makes the script fail
grep -q "All tests passed!" sim.log
